// ==== axil_apb_bridge.f ====
+incdir+logic
logic/axil_apb_bridge_pkg.sv
logic/axil_pause.sv
logic/apb_addr_decode.sv
logic/axil_to_apb.sv
logic/axil_apb_bridge.sv
verification/tb_apb_mem.sv
verification/tb_axil_apb_bridge.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Ilogic
TOP      = tb_axil_apb_bridge
FILELIST = axil_apb_bridge.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== verification/tb_axil_apb_bridge.sv ====
//**************************************************************************
// AXI-Lite to APB bridge testbench
// Random traffic over four APB memories, decode and slave errors, pause
// and response back-pressure, all checked against a reference model
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module tb_axil_apb_bridge
    import axil_apb_bridge_pkg::*;
;

    localparam addr_t WIN_BASE = 32'h1000;
    localparam addr_t WIN_SIZE = 32'h400;
    localparam int TIMEOUT_CYCLES = 300 * 20 + 2000; // ~300 transfers, 20 cycles worst case

    logic                     clk;
    logic                     reset;
    axil_req_t                axil_req;
    axil_resp_t               axil_resp;
    apb_req_t  [`NO_APBS-1:0] apb_req;
    apb_resp_t [`NO_APBS-1:0] apb_resp;
    rule_t     [`NO_APBS-1:0] addr_map;
    logic                     pause_req;
    logic                     pause_ack;
    logic      [`NO_APBS-1:0] stall;
    logic      [`NO_APBS-1:0] psel_vec;

    logic [31:0] lfsr_state = 32'h3edf;
    data_t       ref_mem [`NO_APBS][64];
    int          cycle_count = 0;
    int          setup_count = 0;
    int          seen_port;
    addr_t       seen_paddr;
    prot_t       seen_pprot;
    int          accepted = 0;
    int          completed = 0;

    axil_apb_bridge u_axil_apb_bridge (
        .clk       (clk),
        .reset     (reset),
        .axil_req  (axil_req),
        .axil_resp (axil_resp),
        .apb_req   (apb_req),
        .apb_resp  (apb_resp),
        .addr_map  (addr_map),
        .pause_req (pause_req),
        .pause_ack (pause_ack)
    );

    for (genvar g = 0; g < `NO_APBS; g++) begin : g_mem
        tb_apb_mem #(.PORT_ID(g)) u_mem (
            .clk   (clk),
            .req   (apb_req[g]),
            .resp  (apb_resp[g]),
            .stall (stall[g])
        );
        assign psel_vec[g] = apb_req[g].psel;
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic data_t random_bits(input int n);
        data_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic addr_t win_start(input int p);
        return WIN_BASE * addr_t'(p + 1);
    endfunction

    // Reference model: window lookup, error rules and strobe merge
    function automatic resp_t expected_access(input addr_t addr, input logic write,
                                              input data_t wdata, input strb_t strb,
                                              output data_t rdata, output addr_t offset,
                                              output int port);
        int word;
        rdata  = '0;
        offset = '0;
        port   = -1;
        for (int i = 0; i < `NO_APBS; i++) begin
            if (port < 0 && addr >= win_start(i) && addr < win_start(i) + WIN_SIZE) begin
                port   = i;
                offset = addr - win_start(i);
            end
        end
        if (port < 0) begin
            return RESP_DECERR;
        end
        if (offset >= 32'h100) begin
            return RESP_SLVERR;
        end
        word = int'(offset[7:2]);
        if (write) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    ref_mem[port][word][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        rdata = ref_mem[port][word];
        return RESP_OKAY;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_prot(input string name, input prot_t exp, input prot_t act);
        if (exp !== act) begin
            $display("error %s expected %h actual %h", name, exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // APB side of one serial transaction
    task automatic check_apb_access(input string name, input resp_t exp_resp,
                                    input addr_t exp_off, input int exp_port,
                                    input prot_t exp_prot);
        if (exp_resp == RESP_DECERR) begin
            if (setup_count != 0) report_failure("psel rose for an address outside the map");
        end else begin
            if (setup_count != 1) report_failure("expected exactly one APB access");
            check_addr(name, exp_off, seen_paddr);
            check_prot(name, exp_prot, seen_pprot);
            if (seen_port != exp_port) report_failure("wrong APB port selected");
        end
    endtask

    task automatic write_and_check(input string name, input addr_t addr, input data_t data,
                                   input strb_t strb, input logic check_apb);
        resp_t exp_resp;
        data_t exp_data;
        addr_t exp_off;
        int    exp_port;
        logic  held;
        logic  done;
        resp_t held_resp;
        resp_t act_resp;
        data_t r;
        prot_t prot;
        exp_resp = expected_access(addr, 1'b1, data, strb, exp_data, exp_off, exp_port);
        r    = random_bits(3);
        prot = r[2:0];
        held = 1'b0;
        done = 1'b0;
        @(posedge clk);
        if (check_apb) setup_count = 0;
        axil_req.aw_addr  <= addr;
        axil_req.aw_prot  <= prot;
        axil_req.aw_valid <= 1'b1;
        axil_req.w_data   <= data;
        axil_req.w_strb   <= strb;
        axil_req.w_valid  <= 1'b1;
        do @(posedge clk); while (!axil_resp.aw_ready);
        if (!axil_resp.w_ready) begin
            report_failure("write data not accepted together with its address");
        end
        axil_req.aw_valid <= 1'b0;
        axil_req.w_valid  <= 1'b0;
        while (!done) begin
            r = random_bits(1);
            axil_req.b_ready <= r[0];
            @(posedge clk);
            if (held) begin
                if (!axil_resp.b_valid) report_failure("write response dropped before it was taken");
                check_resp(name, held_resp, axil_resp.b_resp);
            end
            if (axil_resp.b_valid && axil_req.b_ready) begin
                done = 1'b1;
                act_resp = axil_resp.b_resp;
            end else if (axil_resp.b_valid) begin
                held = 1'b1;
                held_resp = axil_resp.b_resp;
            end
        end
        axil_req.b_ready <= 1'b0;
        check_resp(name, exp_resp, act_resp);
        if (check_apb) check_apb_access(name, exp_resp, exp_off, exp_port, prot);
    endtask

    task automatic read_and_check(input string name, input addr_t addr, input logic check_apb);
        resp_t exp_resp;
        data_t exp_data;
        addr_t exp_off;
        int    exp_port;
        logic  held;
        logic  done;
        resp_t held_resp;
        data_t held_data;
        resp_t act_resp;
        data_t act_data;
        data_t r;
        prot_t prot;
        exp_resp = expected_access(addr, 1'b0, '0, '0, exp_data, exp_off, exp_port);
        r    = random_bits(3);
        prot = r[2:0];
        held = 1'b0;
        done = 1'b0;
        @(posedge clk);
        if (check_apb) setup_count = 0;
        axil_req.ar_addr  <= addr;
        axil_req.ar_prot  <= prot;
        axil_req.ar_valid <= 1'b1;
        do @(posedge clk); while (!axil_resp.ar_ready);
        axil_req.ar_valid <= 1'b0;
        while (!done) begin
            r = random_bits(1);
            axil_req.r_ready <= r[0];
            @(posedge clk);
            if (held) begin
                if (!axil_resp.r_valid) report_failure("read response dropped before it was taken");
                check_resp(name, held_resp, axil_resp.r_resp);
                check_data(name, held_data, axil_resp.r_data);
            end
            if (axil_resp.r_valid && axil_req.r_ready) begin
                done = 1'b1;
                act_resp = axil_resp.r_resp;
                act_data = axil_resp.r_data;
            end else if (axil_resp.r_valid) begin
                held = 1'b1;
                held_resp = axil_resp.r_resp;
                held_data = axil_resp.r_data;
            end
        end
        axil_req.r_ready <= 1'b0;
        check_resp(name, exp_resp, act_resp);
        if (exp_resp == RESP_OKAY) check_data(name, exp_data, act_data);
        if (check_apb) check_apb_access(name, exp_resp, exp_off, exp_port, prot);
    endtask

    always @(posedge clk) begin : wait_state_gen
        data_t r;
        r = random_bits(4);
        stall <= r[3:0];
    end

    // Bus monitor and run limit
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout, the run did not finish within the cycle limit");
        end
        if (!reset) begin
            if ($countones(psel_vec) > 1) report_failure("more than one APB port selected");
            for (int p = 0; p < `NO_APBS; p++) begin
                if (apb_req[p].psel && !apb_req[p].penable) begin
                    setup_count = setup_count + 1;
                    seen_port   = p;
                    seen_paddr  = apb_req[p].paddr;
                    seen_pprot  = apb_req[p].pprot;
                end
            end
            if (axil_req.aw_valid && axil_resp.aw_ready) accepted = accepted + 1;
            if (axil_req.ar_valid && axil_resp.ar_ready) accepted = accepted + 1;
            if (axil_resp.b_valid && axil_req.b_ready) completed = completed + 1;
            if (axil_resp.r_valid && axil_req.r_ready) completed = completed + 1;
            if (pause_req && (axil_resp.aw_ready || axil_resp.ar_ready)) begin
                report_failure("request accepted while pause was requested");
            end
            if (pause_ack && (accepted != completed)) begin
                report_failure("pause acknowledged with transactions outstanding");
            end
        end
    end

    initial begin : main_seq
        addr_t wr_addrs [40];
        addr_t a;
        data_t tmp;
        data_t d;
        int    p;
        axil_req  = '0;
        pause_req = 1'b0;
        reset     = 1'b1;
        stall     = '0;
        for (int i = 0; i < `NO_APBS; i++) begin
            addr_map[i].idx        = port_idx_t'(i);
            addr_map[i].start_addr = win_start(i);
            addr_map[i].end_addr   = win_start(i) + WIN_SIZE;
            for (int w = 0; w < 64; w++) begin
                ref_mem[i][w] = {8'hc0 | 8'(i), 16'h5a00, 8'(w)};
            end
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        if (axil_resp.b_valid || axil_resp.r_valid || pause_ack || (psel_vec != '0)) begin
            report_failure("outputs not idle after reset");
        end

        for (int n = 0; n < 40; n++) begin
            tmp = random_bits(2);
            p   = int'(tmp[1:0]);
            tmp = random_bits(6);
            a   = win_start(p) + addr_t'({tmp[5:0], 2'b00});
            d   = random_bits(32);
            tmp = random_bits(4);
            wr_addrs[n] = a;
            write_and_check("random_write", a, d, tmp[3:0], 1'b1);
        end
        for (int n = 0; n < 40; n++) begin
            read_and_check("readback", wr_addrs[n], 1'b1);
        end
        for (int n = 0; n < 20; n++) begin
            tmp = random_bits(2);
            p   = int'(tmp[1:0]);
            tmp = random_bits(6);
            read_and_check("random_read", win_start(p) + addr_t'({tmp[5:0], 2'b00}), 1'b1);
        end

        // Gaps between and after the windows
        for (int n = 0; n < 8; n++) begin
            tmp = random_bits(12);
            if (n == 0) a = 32'h0;
            else if (n == 1) a = 32'h1400;
            else if (n == 2) a = 32'h4ffc;
            else a = 32'h8000 + addr_t'({tmp[11:0], 2'b00});
            d = random_bits(32);
            if (n[0]) read_and_check("decode_error", a, 1'b1);
            else write_and_check("decode_error", a, d, 4'hf, 1'b1);
        end

        for (int n = 0; n < 8; n++) begin
            tmp = random_bits(2);
            p   = int'(tmp[1:0]);
            tmp = random_bits(7);
            a   = win_start(p) + 32'h100 + addr_t'({tmp[6:0], 2'b00});
            d   = random_bits(32);
            if (n[0]) read_and_check("slave_error", a, 1'b1);
            else write_and_check("slave_error", a, d, 4'hf, 1'b1);
        end
        for (int n = 0; n < 40; n++) begin
            read_and_check("readback_after_error", wr_addrs[n], 1'b1);
        end

        // Pause raised with a write in flight and a read arriving later
        fork
            write_and_check("pause_write", win_start(0) + 32'h10, 32'hcafe_f00d, 4'hf, 1'b0);
            begin
                repeat (3) @(posedge clk);
                read_and_check("pause_read", win_start(1) + 32'h20, 1'b0);
            end
            begin
                repeat (2) @(posedge clk);
                pause_req <= 1'b1;
                do @(posedge clk); while (!pause_ack);
                repeat (20) @(posedge clk);
                pause_req <= 1'b0;
            end
        join
        read_and_check("pause_readback", win_start(0) + 32'h10, 1'b1);

        if (pause_ack) begin
            report_failure("pause acknowledge still high after release");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// ==== verification/tb_apb_mem.sv ====
//**************************************************************************
// APB slave memory model
// 64 words with externally driven wait states, error above 256 bytes
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module tb_apb_mem
    import axil_apb_bridge_pkg::*;
#(
    parameter int PORT_ID = 0
) (
    input  logic      clk,
    input  apb_req_t  req,
    output apb_resp_t resp,
    input  logic      stall
);

    data_t mem [64];
    logic  in_range;

    assign in_range = (req.paddr < 32'h100);

    // Fill pattern depends on port and word index
    initial begin
        for (int i = 0; i < 64; i++) begin
            mem[i] = {8'hc0 | 8'(PORT_ID), 16'h5a00, 8'(i)};
        end
    end

    always_comb begin
        resp.pready  = req.psel && req.penable && !stall;
        resp.pslverr = resp.pready && !in_range;
        resp.prdata  = in_range ? mem[req.paddr[7:2]] : '0;
    end

    always @(posedge clk) begin
        if (resp.pready && req.pwrite && in_range) begin
            for (int b = 0; b < 4; b++) begin
                if (req.pstrb[b]) begin
                    mem[req.paddr[7:2]][8*b +: 8] <= req.pwdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/axil_apb_bridge.sv ====
//**************************************************************************
// AXI-Lite to APB bridge subsystem
// Pause gate in front of a single-transaction bridge core with an
// address decoder that maps each window onto its own APB port
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module axil_apb_bridge
    import axil_apb_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  axil_req_t                 axil_req,
    output axil_resp_t                axil_resp,

    output apb_req_t  [`NO_APBS-1:0]  apb_req,
    input  apb_resp_t [`NO_APBS-1:0]  apb_resp,

    input  rule_t     [`NO_APBS-1:0]  addr_map,

    input  logic                      pause_req,
    output logic                      pause_ack
);

    axil_req_t  gated_req;   // After the pause gate
    axil_resp_t gated_resp;

    addr_t      dec_addr;
    logic       dec_hit;
    port_idx_t  dec_idx;
    addr_t      dec_offset;

    axil_pause u_axil_pause (
        .clk       (clk),
        .reset     (reset),
        .pause_req (pause_req),
        .pause_ack (pause_ack),
        .slv_req   (axil_req),
        .slv_resp  (axil_resp),
        .mst_req   (gated_req),
        .mst_resp  (gated_resp)
    );

    apb_addr_decode u_apb_addr_decode (
        .addr     (dec_addr),
        .addr_map (addr_map),
        .hit      (dec_hit),
        .port_idx (dec_idx),
        .offset   (dec_offset)
    );

    axil_to_apb u_axil_to_apb (
        .clk        (clk),
        .reset      (reset),
        .axil_req   (gated_req),
        .axil_resp  (gated_resp),
        .dec_addr   (dec_addr),
        .dec_hit    (dec_hit),
        .dec_idx    (dec_idx),
        .dec_offset (dec_offset),
        .apb_req    (apb_req),
        .apb_resp   (apb_resp)
    );

endmodule

// ==== logic/axil_to_apb.sv ====
//**************************************************************************
// AXI-Lite slave to APB master core
// Takes one read or write at a time, runs the APB setup and access
// phases on the decoded port and returns the AXI-Lite response
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module axil_to_apb
    import axil_apb_bridge_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,

    input  axil_req_t                 axil_req,
    output axil_resp_t                axil_resp,

    output addr_t                     dec_addr,
    input  logic                      dec_hit,
    input  port_idx_t                 dec_idx,
    input  addr_t                     dec_offset,

    output apb_req_t  [`NO_APBS-1:0]  apb_req,
    input  apb_resp_t [`NO_APBS-1:0]  apb_resp
);

    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        RESP
    } state_e;

    state_e    state_q;
    state_e    state_d;

    addr_t     addr_q;
    prot_t     prot_q;
    data_t     wdata_q;
    strb_t     strb_q;
    logic      write_q;       // Direction in flight, or served last when idle
    resp_t     resp_q;
    data_t     rdata_q;

    logic      wr_pend;
    logic      rd_pend;
    logic      take_wr;
    logic      take_rd;
    logic      rsp_valid;
    logic      rsp_ready;
    resp_t     rsp_code;
    data_t     rsp_data;
    apb_resp_t sel_resp;

    assign wr_pend = axil_req.aw_valid && axil_req.w_valid; // AW and W together
    assign rd_pend = axil_req.ar_valid;

    assign take_wr = (state_q == IDLE) && wr_pend && (!rd_pend || !write_q);
    assign take_rd = (state_q == IDLE) && rd_pend && !take_wr;

    assign dec_addr = addr_q;
    assign sel_resp = apb_resp[dec_idx];

    // Decode miss answers straight from the setup cycle
    assign rsp_valid = (state_q == RESP) || ((state_q == SETUP) && !dec_hit);
    assign rsp_ready = write_q ? axil_req.b_ready : axil_req.r_ready;
    assign rsp_code  = (state_q == RESP) ? resp_q  : RESP_DECERR;
    assign rsp_data  = (state_q == RESP) ? rdata_q : '0;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (take_wr || take_rd) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                if (dec_hit) begin
                    state_d = ACCESS;
                end else if (rsp_ready) begin
                    state_d = IDLE;
                end else begin
                    state_d = RESP;    // Hold DECERR until taken
                end
            end
            ACCESS: begin
                if (sel_resp.pready) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (rsp_ready) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
            write_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (take_wr || take_rd) begin
                write_q <= take_wr;
            end
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (take_wr) begin
            addr_q  <= axil_req.aw_addr;
            prot_q  <= axil_req.aw_prot;
            wdata_q <= axil_req.w_data;
            strb_q  <= axil_req.w_strb;
        end else if (take_rd) begin
            addr_q  <= axil_req.ar_addr;
            prot_q  <= axil_req.ar_prot;
        end
        if (state_q == SETUP && !dec_hit) begin
            resp_q  <= RESP_DECERR;
            rdata_q <= '0;
        end else if (state_q == ACCESS && sel_resp.pready) begin
            resp_q  <= sel_resp.pslverr ? RESP_SLVERR : RESP_OKAY;
            rdata_q <= sel_resp.prdata;
        end
    end

    always_comb begin
        axil_resp          = '0;
        axil_resp.aw_ready = take_wr;
        axil_resp.w_ready  = take_wr;
        axil_resp.ar_ready = take_rd;
        axil_resp.b_valid  = rsp_valid && write_q;
        axil_resp.b_resp   = rsp_code;
        axil_resp.r_valid  = rsp_valid && !write_q;
        axil_resp.r_resp   = rsp_code;
        axil_resp.r_data   = rsp_data;
    end

    // Shared APB payload, only the decoded port gets psel
    always_comb begin
        for (int i = 0; i < `NO_APBS; i++) begin
            apb_req[i].paddr   = dec_offset;
            apb_req[i].pprot   = prot_q;
            apb_req[i].pwrite  = write_q;
            apb_req[i].pwdata  = wdata_q;
            apb_req[i].pstrb   = write_q ? strb_q : '0; // No strobes on reads
            apb_req[i].psel    = ((state_q == SETUP) || (state_q == ACCESS)) &&
                                 dec_hit && (dec_idx == port_idx_t'(i));
            apb_req[i].penable = (state_q == ACCESS) && (dec_idx == port_idx_t'(i));
        end
    end

endmodule

// ==== logic/apb_addr_decode.sv ====
//**************************************************************************
// APB address decoder
// Finds the rule covering an address and returns its port and offset
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module apb_addr_decode
    import axil_apb_bridge_pkg::*;
(
    input  addr_t                  addr,
    input  rule_t [`NO_APBS-1:0]   addr_map,

    output logic                   hit,
    output port_idx_t              port_idx,
    output addr_t                  offset
);

    logic [`NO_APBS-1:0] match;

    // Window check per rule, end address exclusive
    always_comb begin
        for (int i = 0; i < `NO_APBS; i++) begin
            match[i] = (addr >= addr_map[i].start_addr) &&
                       (addr <  addr_map[i].end_addr);
        end
    end

    // Scan from the top so the lowest matching rule wins
    always_comb begin
        hit      = 1'b0;
        port_idx = '0;
        offset   = '0;
        for (int i = `NO_APBS - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit      = 1'b1;
                port_idx = addr_map[i].idx;
                offset   = addr - addr_map[i].start_addr; // Slave sees zero-based
            end
        end
    end

endmodule

// ==== logic/axil_pause.sv ====
//**************************************************************************
// AXI-Lite pause gate
// Tracks outstanding transactions and holds off new requests while a
// pause is pending, then acknowledges once the bus has drained
//**************************************************************************

`timescale 1ns/1ps

`include "axil_apb_bridge_cfg.svh"

module axil_pause
    import axil_apb_bridge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       pause_req,
    output logic       pause_ack,

    input  axil_req_t  slv_req,
    output axil_resp_t slv_resp,

    output axil_req_t  mst_req,
    input  axil_resp_t mst_resp
);

    localparam int CNT_W = $clog2(`MAX_OUTSTANDING + 1);

    typedef logic [CNT_W-1:0] cnt_t;

    cnt_t count_q;
    cnt_t count_d;
    logic full;
    logic block;
    logic aw_hs;
    logic ar_hs;
    logic b_hs;
    logic r_hs;

    assign full  = (count_q == cnt_t'(`MAX_OUTSTANDING));
    assign block = pause_req || pause_ack || full;

    // Requests go downstream only while the gate is open
    always_comb begin
        mst_req = slv_req;
        if (block) begin
            mst_req.aw_valid = 1'b0;
            mst_req.w_valid  = 1'b0;
            mst_req.ar_valid = 1'b0;
        end
    end

    // B and R pass straight through, readies are masked
    always_comb begin
        slv_resp = mst_resp;
        if (block) begin
            slv_resp.aw_ready = 1'b0;
            slv_resp.w_ready  = 1'b0;
            slv_resp.ar_ready = 1'b0;
        end
    end

    assign aw_hs = mst_req.aw_valid && mst_resp.aw_ready; // Write counts from AW
    assign ar_hs = mst_req.ar_valid && mst_resp.ar_ready;
    assign b_hs  = mst_resp.b_valid && slv_req.b_ready;
    assign r_hs  = mst_resp.r_valid && slv_req.r_ready;

    always_comb begin
        count_d = count_q + cnt_t'(aw_hs) + cnt_t'(ar_hs);
        count_d = count_d - cnt_t'(b_hs) - cnt_t'(r_hs);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_q   <= '0;
            pause_ack <= 1'b0;
        end else begin
            count_q   <= count_d;
            // Drained and still asked to pause
            pause_ack <= pause_req && (count_q == '0);
        end
    end

endmodule

// ==== logic/axil_apb_bridge_pkg.sv ====
//**************************************************************************
// AXI-Lite to APB bridge types
// Vector typedefs, AXI-Lite channel structs, APB structs and address rules
//**************************************************************************

`include "axil_apb_bridge_cfg.svh"

package axil_apb_bridge_pkg;

    typedef logic [`ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`DATA_WIDTH-1:0]     data_t;
    typedef logic [`DATA_WIDTH/8-1:0]   strb_t;
    typedef logic [1:0]                 resp_t;
    typedef logic [2:0]                 prot_t;
    typedef logic [$clog2(`NO_APBS)-1:0] port_idx_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // One window per APB port, end is exclusive
    typedef struct packed {
        port_idx_t idx;
        addr_t     start_addr;
        addr_t     end_addr;
    } rule_t;

    typedef struct packed {
        addr_t aw_addr;
        prot_t aw_prot;
        logic  aw_valid;
        data_t w_data;
        strb_t w_strb;
        logic  w_valid;
        logic  b_ready;
        addr_t ar_addr;
        prot_t ar_prot;
        logic  ar_valid;
        logic  r_ready;
    } axil_req_t;

    typedef struct packed {
        logic  aw_ready;
        logic  w_ready;
        resp_t b_resp;
        logic  b_valid;
        logic  ar_ready;
        data_t r_data;
        resp_t r_resp;
        logic  r_valid;
    } axil_resp_t;

    typedef struct packed {
        addr_t paddr;
        prot_t pprot;
        logic  psel;
        logic  penable;
        logic  pwrite;
        data_t pwdata;
        strb_t pstrb;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        data_t prdata;
        logic  pslverr;
    } apb_resp_t;

endpackage

// ==== logic/axil_apb_bridge_cfg.svh ====
//**************************************************************************
// AXI-Lite to APB bridge configuration
// Bus widths, APB port count and pause gate capacity
//**************************************************************************

`ifndef AXIL_APB_BRIDGE_CFG_SVH
`define AXIL_APB_BRIDGE_CFG_SVH

// Byte address width of the AXI-Lite port
`define ADDR_WIDTH 32

// Data word width, shared by AXI-Lite and APB
`define DATA_WIDTH 32

// APB ports, one address rule each
`define NO_APBS 4

// Transactions the pause gate lets through before it stalls
`define MAX_OUTSTANDING 2

`endif
